//--- hdl/stream_mem_pkg.sv
`default_nettype none

package stream_mem_pkg;

  typedef logic [7:0] byte_t;     // One stream or memory byte
  typedef logic [15:0] addr_t;    // Byte address, as sent in the header
  typedef logic [7:0] len_t;      // Read length byte, requests len+1 bytes
  typedef logic [7:0] err_cnt_t;  // Saturating malformed-packet count

  // Forward half of a byte stream, tready runs the other way
  typedef struct packed {
    logic  tvalid;
    logic  tlast;
    logic  tkeep;
    byte_t tdata;
  } axis_beat_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
    byte_t data;
  } mem_wr_t;

  // Single-cycle read request from the parser to the streamer
  typedef struct packed {
    logic  valid;
    addr_t addr;
    len_t  len;
  } rd_req_t;

  localparam byte_t OP_WRITE = 8'hA0;
  localparam byte_t OP_READ = 8'hB0;

  typedef enum logic [2:0] {
    ST_OPCODE,
    ST_ADDR_HI,
    ST_ADDR_LO,
    ST_LEN,
    ST_PAYLOAD,
    ST_DRAIN,
    ST_WAIT_READ
  } parse_state_e;

endpackage  /* stream_mem_pkg */

`default_nettype wire

//--- hdl/cmd_parser.sv
`default_nettype none

module cmd_parser #(
  parameter int ADDR_WIDTH = 11
) (
  input  wire                        clock_i,
  input  wire                        rst_i,
  input  stream_mem_pkg::axis_beat_t s_beat_i,
  output logic                       s_tready_o,
  output stream_mem_pkg::mem_wr_t    mem_wr_o,
  output stream_mem_pkg::rd_req_t    rd_req_o,
  input  wire                        rd_done_i,
  output stream_mem_pkg::err_cnt_t   err_count_o
);

  import stream_mem_pkg::*;

  // Keeps addresses inside the memory
  localparam addr_t ADDR_MASK = addr_t'((32'd1 << ADDR_WIDTH) - 32'd1);

  parse_state_e state_q;
  logic         is_read_q;    // Current packet is a read command
  logic         read_armed_q; // Length byte seen, waiting on tlast
  byte_t        addr_hi_q;
  addr_t        addr_q;       // Write pointer, or start of the read
  mem_wr_t      mem_wr_q;
  rd_req_t      rd_req_q;
  logic         err_pulse_q;
  err_cnt_t     err_cnt_q;
  logic         xfer;

  // Input stalls only while a read is being returned
  assign s_tready_o  = (state_q != ST_WAIT_READ);
  assign xfer        = s_beat_i.tvalid && s_tready_o;

  assign mem_wr_o    = mem_wr_q;
  assign rd_req_o    = rd_req_q;
  assign err_count_o = err_cnt_q;

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      state_q        <= ST_OPCODE;
      is_read_q      <= 1'b0;
      read_armed_q   <= 1'b0;
      mem_wr_q.en    <= 1'b0;
      rd_req_q.valid <= 1'b0;
      err_pulse_q    <= 1'b0;
      err_cnt_q      <= '0;
    end else begin
      mem_wr_q.en    <= 1'b0;
      rd_req_q.valid <= 1'b0;
      err_pulse_q    <= 1'b0;

      if (err_pulse_q && err_cnt_q != '1) begin
        err_cnt_q <= err_cnt_q + 1'b1;
      end

      if (xfer) begin
        // Later assignments win, so tlast handling follows the data step
        case (state_q)
          ST_OPCODE: begin
            if (s_beat_i.tkeep) begin
              if (s_beat_i.tdata == OP_WRITE || s_beat_i.tdata == OP_READ) begin
                is_read_q <= (s_beat_i.tdata == OP_READ);
                state_q   <= ST_ADDR_HI;
              end else begin
                read_armed_q <= 1'b0;
                state_q      <= ST_DRAIN;  // Unknown opcode
              end
            end
            if (s_beat_i.tlast) begin
              state_q     <= ST_OPCODE;
              err_pulse_q <= s_beat_i.tkeep && (s_beat_i.tdata != OP_WRITE);
            end
          end

          ST_ADDR_HI: begin
            if (s_beat_i.tkeep) begin
              addr_hi_q <= s_beat_i.tdata;
              state_q   <= ST_ADDR_LO;
            end
            if (s_beat_i.tlast) begin
              state_q     <= ST_OPCODE;
              err_pulse_q <= is_read_q;  // Short write is just dropped
            end
          end

          ST_ADDR_LO: begin
            if (s_beat_i.tkeep) begin
              addr_q  <= {addr_hi_q, s_beat_i.tdata} & ADDR_MASK;
              state_q <= is_read_q ? ST_LEN : ST_PAYLOAD;
            end
            if (s_beat_i.tlast) begin
              state_q     <= ST_OPCODE;
              err_pulse_q <= is_read_q;
            end
          end

          ST_LEN: begin
            if (s_beat_i.tkeep) begin
              rd_req_q.addr <= addr_q;
              rd_req_q.len  <= s_beat_i.tdata;
              if (s_beat_i.tlast) begin
                rd_req_q.valid <= 1'b1;
                state_q        <= ST_WAIT_READ;
              end else begin
                read_armed_q <= 1'b1;  // Trailing bytes before tlast
                state_q      <= ST_DRAIN;
              end
            end else if (s_beat_i.tlast) begin
              err_pulse_q <= 1'b1;
              state_q     <= ST_OPCODE;
            end
          end

          ST_PAYLOAD: begin
            if (s_beat_i.tkeep) begin
              mem_wr_q.en   <= 1'b1;
              mem_wr_q.addr <= addr_q;
              mem_wr_q.data <= s_beat_i.tdata;
              addr_q        <= (addr_q + 1'b1) & ADDR_MASK;
            end
            if (s_beat_i.tlast) begin
              state_q <= ST_OPCODE;
            end
          end

          ST_DRAIN: begin
            if (s_beat_i.tlast) begin
              if (read_armed_q) begin
                rd_req_q.valid <= 1'b1;
                state_q        <= ST_WAIT_READ;
              end else begin
                err_pulse_q <= 1'b1;
                state_q     <= ST_OPCODE;
              end
            end
          end

          default: state_q <= ST_OPCODE;
        endcase
      end

      if (state_q == ST_WAIT_READ && rd_done_i) begin
        state_q <= ST_OPCODE;
      end
    end
  end

endmodule  /* cmd_parser */

`default_nettype wire

//--- hdl/byte_sram.sv
`default_nettype none

module byte_sram #(
  parameter int ADDR_WIDTH = 11
) (
  input  wire                     clock_i,
  input  stream_mem_pkg::mem_wr_t mem_wr_i,
  input  stream_mem_pkg::addr_t   rd_addr_i,
  output stream_mem_pkg::byte_t   rd_data_o
);

  import stream_mem_pkg::*;

  localparam int DEPTH = 1 << ADDR_WIDTH;

  byte_t mem_q [DEPTH];

  logic [ADDR_WIDTH-1:0] wr_index;
  logic [ADDR_WIDTH-1:0] rd_index;

  // Upper address bits are ignored, so accesses wrap
  assign wr_index = mem_wr_i.addr[ADDR_WIDTH-1:0];
  assign rd_index = rd_addr_i[ADDR_WIDTH-1:0];

  always_ff @(posedge clock_i) begin
    if (mem_wr_i.en) begin
      mem_q[wr_index] <= mem_wr_i.data;
    end
    rd_data_o <= mem_q[rd_index];  // Old data on a same-address write
  end

endmodule  /* byte_sram */

`default_nettype wire

//--- hdl/read_streamer.sv
`default_nettype none

module read_streamer #(
  parameter int ADDR_WIDTH = 11
) (
  input  wire                        clock_i,
  input  wire                        rst_i,
  input  stream_mem_pkg::rd_req_t    rd_req_i,
  output stream_mem_pkg::addr_t      rd_addr_o,
  input  stream_mem_pkg::byte_t      rd_data_i,
  output stream_mem_pkg::axis_beat_t m_beat_o,
  input  wire                        m_tready_i,
  output logic                       rd_done_o
);

  import stream_mem_pkg::*;

  localparam addr_t ADDR_MASK = addr_t'((32'd1 << ADDR_WIDTH) - 32'd1);

  addr_t               fetch_addr_q;
  logic [$bits(len_t):0] left_q;  // Bytes still to fetch, up to 256
  logic                inflight_q;      // RAM returns a byte this cycle
  logic                inflight_last_q;

  logic  out_valid_q;
  logic  out_last_q;
  byte_t out_data_q;
  logic  skid_valid_q;
  logic  skid_last_q;
  byte_t skid_data_q;
  logic  done_q;

  logic       pop;
  logic [1:0] held;
  logic       fetch;

  assign pop  = out_valid_q && m_tready_i;
  assign held = 2'(out_valid_q) + 2'(skid_valid_q) + 2'(inflight_q);

  // Only fetch when the returning byte is sure to find a free register
  assign fetch = (left_q != '0) && ((held - 2'(pop)) < 2'd2);

  assign rd_addr_o = fetch_addr_q;
  assign rd_done_o = done_q;
  assign m_beat_o  = '{tvalid: out_valid_q, tlast: out_last_q, tkeep: 1'b1,
                       tdata: out_data_q};

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      left_q       <= '0;
      inflight_q   <= 1'b0;
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      done_q     <= pop && out_last_q;
      inflight_q <= fetch;

      if (rd_req_i.valid) begin
        fetch_addr_q <= rd_req_i.addr & ADDR_MASK;
        left_q       <= {1'b0, rd_req_i.len} + 1'b1;
      end else if (fetch) begin
        fetch_addr_q    <= (fetch_addr_q + 1'b1) & ADDR_MASK;
        left_q          <= left_q - 1'b1;
        inflight_last_q <= (left_q == 1);
      end

      if (!out_valid_q || pop) begin
        if (skid_valid_q) begin
          out_valid_q  <= 1'b1;
          out_last_q   <= skid_last_q;
          out_data_q   <= skid_data_q;
          skid_valid_q <= inflight_q;
          skid_last_q  <= inflight_last_q;
          skid_data_q  <= rd_data_i;
        end else begin
          out_valid_q <= inflight_q;
          out_last_q  <= inflight_last_q;
          out_data_q  <= rd_data_i;
        end
      end else if (inflight_q) begin
        // Output stalled, park the returning byte
        skid_valid_q <= 1'b1;
        skid_last_q  <= inflight_last_q;
        skid_data_q  <= rd_data_i;
      end
    end
  end

endmodule  /* read_streamer */

`default_nettype wire

//--- hdl/stream_mem_top.sv
`default_nettype none

module stream_mem_top #(
  parameter int ADDR_WIDTH = 11  // 2048-byte memory
) (
  input  wire                        clock_i,
  input  wire                        rst_i,

  // Host-side command stream
  input  stream_mem_pkg::axis_beat_t s_beat_i,
  output logic                       s_tready_o,

  // Read data back to the host
  output stream_mem_pkg::axis_beat_t m_beat_o,
  input  wire                        m_tready_i,

  output stream_mem_pkg::err_cnt_t   err_count_o
);

  import stream_mem_pkg::*;

  mem_wr_t mem_wr;
  rd_req_t rd_req;
  addr_t   rd_addr;
  byte_t   rd_data;
  logic    rd_done;

  cmd_parser #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) parser_inst (
    .clock_i    (clock_i),
    .rst_i      (rst_i),
    .s_beat_i   (s_beat_i),
    .s_tready_o (s_tready_o),
    .mem_wr_o   (mem_wr),
    .rd_req_o   (rd_req),
    .rd_done_i  (rd_done),  // Releases the input stream
    .err_count_o(err_count_o)
  );

  byte_sram #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) sram_inst (
    .clock_i  (clock_i),
    .mem_wr_i (mem_wr),
    .rd_addr_i(rd_addr),
    .rd_data_o(rd_data)
  );

  read_streamer #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) streamer_inst (
    .clock_i   (clock_i),
    .rst_i     (rst_i),
    .rd_req_i  (rd_req),
    .rd_addr_o (rd_addr),
    .rd_data_i (rd_data),
    .m_beat_o  (m_beat_o),
    .m_tready_i(m_tready_i),
    .rd_done_o (rd_done)
  );

endmodule  /* stream_mem_top */

`default_nettype wire

//--- dv/stream_mem_tb.sv
`default_nettype none

module stream_mem_tb;

  import stream_mem_pkg::*;

  localparam int ADDR_WIDTH = 11;
  localparam int MEM_SIZE = 1 << ADDR_WIDTH;
  localparam int TEST_CYCLES = 5000;  // Upper bound on the summed length of all tests
  localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

  logic       clock = 1'b0;
  logic       rst = 1'b1;
  axis_beat_t s_beat = '0;
  logic       s_tready;
  axis_beat_t m_beat;
  logic       m_tready = 1'b1;
  err_cnt_t   err_count;

  byte_t       model_mem [MEM_SIZE];
  int          model_err = 0;
  byte_t       exp_data_q [$];  // Bytes the next reads must return
  logic        exp_last_q [$];
  byte_t       exp_byte;
  logic        exp_last;
  logic        rand_ready = 1'b0;
  string       test_name = "reset";
  int          cycles = 0;
  int          value_errs = 0;
  int          proto_errs = 0;
  int          other_errs = 0;
  int          kept;
  int          offset;
  addr_t       base;
  byte_t       raw_data [$];
  logic        raw_keep [$];
  int unsigned seed = 32'hd4c4e2fe;

  stream_mem_top #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) dut (
    .clock_i    (clock),
    .rst_i      (rst),
    .s_beat_i   (s_beat),
    .s_tready_o (s_tready),
    .m_beat_o   (m_beat),
    .m_tready_i (m_tready),
    .err_count_o(err_count)
  );

  always #10 clock = ~clock;

  // Output side ready goes random only in the back-pressure test
  always @(negedge clock) begin
    m_tready = rand_ready ? (($urandom % 3) != 0) : 1'b1;
  end

  assert property (@(posedge clock) disable iff (rst)
                   m_beat.tvalid && !m_tready |=> $stable(m_beat))
    else begin
      proto_errs++;
      $display("Output beat changed while stalled in test %s", test_name);
    end

  assert property (@(posedge clock) rst && $past(rst) |-> !m_beat.tvalid)
    else begin
      proto_errs++;
      $display("Output beat was valid during reset");
    end

  task automatic check_equal(input string what, input int expected, input int actual);
    assert (actual == expected)
      else begin
        value_errs++;
        $display("FAIL %s %s: expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
      end
  endtask

  // Receive monitor checks each transferred beat against the model
  always @(posedge clock) begin
    if (!rst && m_beat.tvalid && m_tready) begin
      assert (exp_data_q.size() != 0)
        else begin
          other_errs++;
          $display("Output beat 0x%02h arrived with no read pending in test %s",
                   m_beat.tdata, test_name);
        end
      if (exp_data_q.size() != 0) begin
        exp_byte = exp_data_q.pop_front();
        exp_last = exp_last_q.pop_front();
        check_equal("tdata", exp_byte, m_beat.tdata);
        check_equal("tlast", exp_last, m_beat.tlast);
        check_equal("tkeep", 1, m_beat.tkeep);
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still going after %0d cycles in test %s", cycles, test_name);
      $display("Checks failed");
      $finish;
    end
  end

  // Sends one packet with tlast on the final byte
  task automatic send_raw(input byte_t data [$], input logic keep [$]);
    for (int i = 0; i < data.size(); i++) begin
      @(negedge clock);
      s_beat = '{tvalid: 1'b1, tlast: (i == data.size() - 1), tkeep: keep[i],
                 tdata: data[i]};
      @(posedge clock);
      while (!s_tready) @(posedge clock);
    end
    @(negedge clock);
    s_beat = '0;
  endtask

  task automatic send_write(input addr_t addr, input int count, input logic sparse,
                            output int n_kept);
    byte_t data [$];
    logic  keep [$];
    int    wr_ptr;
    byte_t value;
    logic  use_it;
    wr_ptr = int'(addr) % MEM_SIZE;
    n_kept = 0;
    data.push_back(OP_WRITE);
    data.push_back(addr[15:8]);
    data.push_back(addr[7:0]);
    repeat (3) keep.push_back(1'b1);
    for (int i = 0; i < count; i++) begin
      value  = byte_t'($urandom);
      use_it = !sparse || (i == 0) || (($urandom % 4) != 0);
      data.push_back(value);
      keep.push_back(use_it);
      if (use_it) begin  // Dropped bytes leave the pointer alone
        model_mem[wr_ptr] = value;
        wr_ptr = (wr_ptr + 1) % MEM_SIZE;
        n_kept++;
      end
    end
    send_raw(data, keep);
  endtask

  task automatic expect_read(input addr_t addr, input len_t n);
    int rd_ptr;
    rd_ptr = int'(addr) % MEM_SIZE;
    for (int i = 0; i <= int'(n); i++) begin
      exp_data_q.push_back(model_mem[rd_ptr]);
      exp_last_q.push_back(i == int'(n));
      rd_ptr = (rd_ptr + 1) % MEM_SIZE;
    end
  endtask

  task automatic send_read(input addr_t addr, input len_t n);
    byte_t data [$];
    logic  keep [$];
    data.push_back(OP_READ);
    data.push_back(addr[15:8]);
    data.push_back(addr[7:0]);
    data.push_back(n);
    repeat (4) keep.push_back(1'b1);
    expect_read(addr, n);
    send_raw(data, keep);
    while (exp_data_q.size() != 0) @(negedge clock);
    while (!s_tready) @(negedge clock);  // Input reopens after rd_done
  endtask

  task automatic check_err_count();
    repeat (3) @(negedge clock);
    check_equal("err_count", model_err, err_count);
  endtask

  initial begin
    void'($urandom(seed));
    repeat (5) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
    @(negedge clock);
    check_equal("tvalid", 0, m_beat.tvalid);
    check_equal("s_tready", 1, s_tready);
    check_equal("err_count", 0, err_count);

    test_name = "write_read";
    base = addr_t'($urandom % MEM_SIZE);
    send_write(base, 256, 1'b0, kept);
    send_read(base, 8'd255);
    repeat (3) begin
      offset = $urandom % 128;
      send_read(base + addr_t'(offset), len_t'($urandom % 128));
    end

    test_name = "backpressure";
    @(posedge clock);
    rand_ready = 1'b1;
    send_read(base, 8'd255);
    repeat (4) begin
      offset = $urandom % 128;
      send_read(base + addr_t'(offset), len_t'($urandom % 128));
    end
    @(posedge clock);
    rand_ready = 1'b0;

    test_name = "keep_low";
    base = addr_t'($urandom % MEM_SIZE);
    send_write(base, 48, 1'b1, kept);
    send_read(base, len_t'(kept - 1));

    // Upper address bits are set here and must be ignored
    test_name = "wrap";
    send_write(16'hF7F4, 24, 1'b0, kept);
    send_read(16'h07F8, 8'd15);

    test_name = "bad_packets";
    raw_data = '{8'h55, 8'h12, 8'h34, 8'h56};
    raw_keep = '{1'b1, 1'b1, 1'b1, 1'b1};
    send_raw(raw_data, raw_keep);
    model_err++;
    check_err_count();
    raw_data = '{OP_READ, 8'h01, 8'h20};  // Ends before the length byte
    raw_keep = '{1'b1, 1'b1, 1'b1};
    send_raw(raw_data, raw_keep);
    model_err++;
    check_err_count();
    base = addr_t'($urandom % MEM_SIZE);
    send_write(base, 16, 1'b0, kept);
    send_read(base, 8'd15);
    check_err_count();

    $display("Error counts: %0d value, %0d protocol, %0d other",
             value_errs, proto_errs, other_errs);
    if (value_errs + proto_errs + other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
hdl/stream_mem_pkg.sv
hdl/cmd_parser.sv
hdl/byte_sram.sv
hdl/read_streamer.sv
hdl/stream_mem_top.sv
dv/stream_mem_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = stream_mem_tb
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All checks passed

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
